//--- all.f
verilog/hdmi_packet_pkg.sv
verilog/audio_pkg.sv
verilog/audio_sample_collector.sv
verilog/audio_clock_regen.sv
verilog/audio_sample_packet.sv
verilog/info_frames.sv
verilog/packet_picker.sv
verilog/hdmi_packet_top.sv
verif/packet_picker_tb.sv

//--- Makefile
# Verilator build and run for the HDMI packet source testbench

TOP       ?= packet_picker_tb
FLAGS     ?= --binary --timing --assert -Wno-fatal
SEED      ?= 55
VERILATOR ?= verilator
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/packet_picker_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expects 48 kHz, 16-bit audio and the first ACR wrap after the table's InfoFrame slots
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module packet_picker_tb
    import hdmi_packet_pkg::*;
    import audio_pkg::*;
();

timeunit 1ns;
timeprecision 1ps;

localparam int VIDEO_RATE = 25_200_000;
localparam int AUDIO_RATE = 48000;
localparam int ACR_N = 64;
// Two pairs per packet at 48 kHz
localparam int MAX_PAIRS = 2;
localparam logic [23:0] WORD_MASK = 24'hFFFF00;
localparam longint CTS = longint'(VIDEO_RATE) * longint'(ACR_N) / (128 * longint'(AUDIO_RATE));
// Margin covers the reset and clock-crossing latency of the wrap level
localparam int ACR_WAIT = ACR_N + 8;
localparam int STEPS = 16;
localparam int BLOCK_PACKETS = 100;
localparam longint WATCHDOG_NS = 20 * (STEPS * 40 + ACR_WAIT * 7 + BLOCK_PACKETS * 40 + 200);

typedef struct packed {
    logic [2:0] push;
    logic       field_end;
    logic       enable;
    logic [7:0] expected;
} step_t;

logic           clk_pixel = 1'b0;
logic           clk_audio = 1'b0;
logic           audio_buffer_rst;
logic           sample_strobe;
audio_pair_t    audio_sample_word;
logic           video_field_end;
logic           packet_enable;
logic [4:0]     packet_pixel_counter;
logic [7:0]     packet_type;
packet_header_t header;
packet_body_t   body;

step_t       steps [STEPS];
audio_pair_t pushed [$];
int          seed;
int          audio_edges = 0;
int          frames = 0;
int          block_starts = 0;
int          error_count = 0;

hdmi_packet_top #(.VIDEO_RATE(VIDEO_RATE), .AUDIO_RATE(AUDIO_RATE), .AUDIO_BIT_WIDTH(16),
                  .ACR_N(ACR_N)) dut_i (.*);

always #10 clk_pixel = ~clk_pixel;
always #70 clk_audio = ~clk_audio;

always @(posedge clk_audio)
begin
    if (!audio_buffer_rst)
        audio_edges++;
end

initial
begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
end

task automatic report_error(input string what);
    error_count++;
    $display("** Error at %0d ns: %s", $time, what);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first error");
endtask

function automatic logic [55:0] expected_subpacket(input audio_pair_t pair);
    logic [23:0] left;
    logic [23:0] right;
    left = pair.left & WORD_MASK;
    right = pair.right & WORD_MASK;
    // Even parity over each word sits at bits 51 and 55
    return {^right, 3'b000, ^left, 3'b000, right, left};
endfunction

function automatic logic [55:0] acr_subpacket();
    logic [19:0] cts;
    logic [19:0] n;
    cts = 20'(CTS);
    n = 20'(ACR_N);
    return {n[7:0], n[15:8], 4'h0, n[19:16], cts[7:0], cts[15:8], 4'h0, cts[19:16], 8'h00};
endfunction

task automatic push_pair();
    audio_pair_t pair;
    pair.left = 24'($random(seed));
    pair.right = 24'($random(seed));
    @(negedge clk_audio);
    sample_strobe = 1'b1;
    audio_sample_word = pair;
    @(negedge clk_audio);
    sample_strobe = 1'b0;
    pushed.push_back(pair);
endtask

task automatic check_audio(input int count);
    logic [3:0] starts;
    starts = 4'b0000;
    for (int i = 0; i < count; i++)
    begin
        if ((frames + i) % 192 == 0)
            starts[i] = 1'b1;
    end
    assert (header.hb1 == 8'(4'((1 << count) - 1)))
    else report_error($sformatf("hb1 %h for %0d pairs", header.hb1, count));
    assert (header.hb2 == {starts, 4'b0000})
    else report_error($sformatf("hb2 %h, expected %h at frame %0d", header.hb2,
                                {starts, 4'b0000}, frames));
    block_starts += $countones(header.hb2[7:4]);
    for (int i = 0; i < 4; i++)
    begin
        assert (body[i] == (i < count ? expected_subpacket(pushed[i]) : 56'd0))
        else report_error($sformatf("audio subpacket %0d is %h", i, body[i]));
    end
    for (int i = 0; i < count; i++)
        void'(pushed.pop_front());
    frames = (frames + count) % 192;
endtask

task automatic check_info(input logic [7:0] kind);
    logic [7:0] sum;
    logic [7:0] version;
    logic [7:0] length;
    version = (kind == PKT_AVI) ? 8'd2 : 8'd1;
    length = (kind == PKT_AVI) ? 8'd13 : (kind == PKT_SPD) ? 8'd25 : 8'd10;
    sum = header.hb0 + header.hb1 + header.hb2;
    for (int i = 0; i < 28; i++)
        sum = sum + body[i / 7][8 * (i % 7) +: 8];
    assert (sum == 8'd0) else report_error($sformatf("InfoFrame %h sums to %h", kind, sum));
    assert (header.hb1 == version && header.hb2 == length)
    else report_error($sformatf("InfoFrame %h version %0d length %0d", kind, header.hb1,
                                header.hb2));
endtask

task automatic check_packet(input logic [7:0] expected, input int count);
    assert (packet_type == expected)
    else report_error($sformatf("packet type %h, expected %h", packet_type, expected));
    assert (header.hb0 == expected)
    else report_error($sformatf("hb0 %h, expected %h", header.hb0, expected));
    case (expected)
        PKT_NULL:
            assert (header == '0 && body == '0) else report_error("null packet is not all zero");
        PKT_ACR:
        begin
            assert (header.hb1 == 8'd0 && header.hb2 == 8'd0) else report_error("ACR header");
            for (int i = 0; i < 4; i++)
                assert (body[i] == acr_subpacket())
                else report_error($sformatf("ACR subpacket %0d is %h", i, body[i]));
        end
        PKT_AUDIO_SAMPLE: check_audio(count);
        default: check_info(expected);
    endcase
endtask

task automatic run_step(input step_t step);
    int count;
    for (int i = 0; i < step.push; i++)
        push_pair();
    if (step.push != 0)
        repeat (3) @(negedge clk_pixel);
    if (step.expected == PKT_ACR)
    begin
        while (audio_edges < ACR_WAIT)
            @(negedge clk_pixel);
    end
    count = (pushed.size() > MAX_PAIRS) ? MAX_PAIRS : pushed.size();
    @(negedge clk_pixel);
    video_field_end = step.field_end;
    packet_enable = step.enable;
    @(negedge clk_pixel);
    video_field_end = 1'b0;
    packet_enable = 1'b0;
    check_packet(step.expected, count);
    // End of the data island, where the frame counter moves on
    @(negedge clk_pixel);
    packet_pixel_counter = 5'd31;
    @(negedge clk_pixel);
    packet_pixel_counter = 5'd0;
endtask

initial
begin
    seed = 55;
    audio_buffer_rst = 1'b1;
    sample_strobe = 1'b0;
    audio_sample_word = '0;
    video_field_end = 1'b0;
    packet_enable = 1'b0;
    packet_pixel_counter = 5'd0;

    steps[0] = '{3'd0, 1'b0, 1'b1, PKT_AUDIO_INFO};
    steps[1] = '{3'd0, 1'b0, 1'b1, PKT_AVI};
    steps[2] = '{3'd0, 1'b0, 1'b1, PKT_SPD};
    steps[3] = '{3'd0, 1'b0, 1'b1, PKT_NULL};
    steps[4] = '{3'd0, 1'b0, 1'b1, PKT_NULL};
    steps[5] = '{3'd0, 1'b1, 1'b0, PKT_NULL};
    steps[6] = '{3'd0, 1'b0, 1'b1, PKT_AUDIO_INFO};
    steps[7] = '{3'd2, 1'b0, 1'b1, PKT_AUDIO_SAMPLE};
    steps[8] = '{3'd0, 1'b0, 1'b1, PKT_AVI};
    steps[9] = '{3'd0, 1'b0, 1'b1, PKT_SPD};
    steps[10] = '{3'd0, 1'b0, 1'b1, PKT_NULL};
    steps[11] = '{3'd1, 1'b0, 1'b1, PKT_AUDIO_SAMPLE};
    steps[12] = '{3'd0, 1'b0, 1'b1, PKT_ACR};
    steps[13] = '{3'd0, 1'b1, 1'b0, PKT_NULL};
    steps[14] = '{3'd0, 1'b0, 1'b1, PKT_AUDIO_INFO};
    steps[15] = '{3'd0, 1'b0, 1'b1, PKT_AVI};

    repeat (4) @(posedge clk_pixel);
    @(negedge clk_pixel);
    audio_buffer_rst = 1'b0;

    for (int s = 0; s < STEPS; s++)
        run_step(steps[s]);

    // More than one IEC 60958 block of frames
    for (int p = 0; p < BLOCK_PACKETS; p++)
        run_step('{3'd2, 1'b0, 1'b1, PKT_AUDIO_SAMPLE});
    assert (block_starts >= 2)
    else report_error("block-start flag did not come back after 192 frames");

    if (error_count == 0)
    begin
        $display("STATUS: PASS");
        $finish;
    end
    else
    begin
        $display("STATUS: FAIL");
        $fatal(1, "checks failed");
    end
end

endmodule

//--- verilog/hdmi_packet_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// No TMDS or BCH here; the timing strobes come from outside
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module hdmi_packet_top
    import hdmi_packet_pkg::*;
    import audio_pkg::*;
#(
    parameter int           VIDEO_ID_CODE       = 1,
    parameter int           VIDEO_RATE          = 25_200_000,
    parameter int           AUDIO_RATE          = 48000,
    parameter int           AUDIO_BIT_WIDTH     = 16,
    parameter int           ACR_N               = 6144,
    parameter logic [63:0]  VENDOR_NAME         = "Unknown ",
    parameter logic [127:0] PRODUCT_DESCRIPTION = "FPGA HDMI Source"
)
(
    input  logic           clk_pixel,
    input  logic           clk_audio,
    input  logic           audio_buffer_rst,
    input  logic           sample_strobe,
    input  audio_pair_t    audio_sample_word,
    input  logic           video_field_end,
    input  logic           packet_enable,
    input  logic [4:0]     packet_pixel_counter,
    output logic [7:0]     packet_type,
    output packet_header_t header,
    output packet_body_t   body
);

logic [2:0]        samples_waiting;
logic [3:0]        samples_present;
audio_pair_t [3:0] sample_buffer;
logic              take_samples;
logic              acr_wrap;
logic [7:0]        frame_counter;
packet_t           acr_packet;
packet_t           audio_packet;
packet_t           info_packet;
packet_t           chosen;

audio_sample_collector #(.AUDIO_BIT_WIDTH(AUDIO_BIT_WIDTH),
                         .DEPTH(max_samples_per_packet(AUDIO_RATE))) collector_i (.*);

audio_clock_regen #(.VIDEO_RATE(VIDEO_RATE), .AUDIO_RATE(AUDIO_RATE), .ACR_N(ACR_N))
    acr_i (.packet(acr_packet), .*);

audio_sample_packet #(.AUDIO_RATE(AUDIO_RATE), .AUDIO_BIT_WIDTH(AUDIO_BIT_WIDTH))
    sample_packet_i (.latch(take_samples), .packet(audio_packet), .*);

info_frames #(.VIDEO_ID_CODE(VIDEO_ID_CODE), .AUDIO_RATE(AUDIO_RATE),
              .AUDIO_BIT_WIDTH(AUDIO_BIT_WIDTH), .VENDOR_NAME(VENDOR_NAME),
              .PRODUCT_DESCRIPTION(PRODUCT_DESCRIPTION)) info_i (.packet(info_packet), .*);

packet_picker #(.AUDIO_RATE(AUDIO_RATE)) picker_i (.*);

// Pairs fill from slot 0, so the count maps to a run of present bits
always_comb
begin
    for (int i = 0; i < 4; i++)
        samples_present[i] = samples_waiting > 3'(i);
end

always_comb
begin
    case (packet_type)
        PKT_ACR:                        chosen = acr_packet;
        PKT_AUDIO_SAMPLE:               chosen = audio_packet;
        PKT_AUDIO_INFO, PKT_AVI, PKT_SPD: chosen = info_packet;
        default:                        chosen = '0;
    endcase
end

assign header = chosen.header;
assign body = chosen.body;

endmodule

//--- verilog/packet_picker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// One packet per packet_enable; video_field_end wins over it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module packet_picker
    import hdmi_packet_pkg::*;
    import audio_pkg::*;
#(
    parameter int AUDIO_RATE = 48000
)
(
    input  logic       clk_pixel,
    input  logic       audio_buffer_rst,
    input  logic       video_field_end,
    input  logic       packet_enable,
    input  logic [4:0] packet_pixel_counter,
    input  logic [2:0] samples_waiting,
    input  logic       acr_wrap,
    output logic [7:0] packet_type,
    output logic       take_samples,
    output logic [7:0] frame_counter
);

localparam int MAX_SAMPLES = max_samples_per_packet(AUDIO_RATE);

logic       audio_info_sent;
logic       avi_sent;
logic       spd_sent;
logic       acr_wrap_seen;
logic [2:0] samples_sent;
logic [8:0] frame_sum;

always_ff @(posedge clk_pixel)
begin
    if (audio_buffer_rst)
    begin
        packet_type <= PKT_NULL;
        take_samples <= 1'b0;
        audio_info_sent <= 1'b0;
        avi_sent <= 1'b0;
        spd_sent <= 1'b0;
        acr_wrap_seen <= acr_wrap;
    end
    else
    begin
        take_samples <= 1'b0;
        if (video_field_end)
        begin
            // InfoFrames go out again in every field
            audio_info_sent <= 1'b0;
            avi_sent <= 1'b0;
            spd_sent <= 1'b0;
            packet_type <= PKT_NULL;
        end
        else if (packet_enable)
        begin
            if (samples_waiting != 3'd0)
            begin
                packet_type <= PKT_AUDIO_SAMPLE;
                take_samples <= 1'b1;
            end
            else if (acr_wrap != acr_wrap_seen)
            begin
                packet_type <= PKT_ACR;
                acr_wrap_seen <= acr_wrap;
            end
            else if (!audio_info_sent)
            begin
                packet_type <= PKT_AUDIO_INFO;
                audio_info_sent <= 1'b1;
            end
            else if (!avi_sent)
            begin
                packet_type <= PKT_AVI;
                avi_sent <= 1'b1;
            end
            else if (!spd_sent)
            begin
                packet_type <= PKT_SPD;
                spd_sent <= 1'b1;
            end
            else
                packet_type <= PKT_NULL;
        end
    end
end

assign frame_sum = {1'b0, frame_counter} + {6'd0, samples_sent};

// IEC 60958 frame position, one block is 192 frames
always_ff @(posedge clk_pixel)
begin
    if (audio_buffer_rst)
    begin
        frame_counter <= 8'd0;
        samples_sent <= 3'd0;
    end
    else
    begin
        if (take_samples)
            samples_sent <= (samples_waiting > 3'(MAX_SAMPLES)) ? 3'(MAX_SAMPLES)
                                                                : samples_waiting;
        if (packet_pixel_counter == 5'd31 && packet_type == PKT_AUDIO_SAMPLE)
            frame_counter <= (frame_sum >= 9'd192) ? 8'(frame_sum - 9'd192) : frame_sum[7:0];
    end
end

take_with_audio: assert property (@(posedge clk_pixel) disable iff (audio_buffer_rst)
    take_samples |-> packet_type == PKT_AUDIO_SAMPLE && samples_waiting != 3'd0);

endmodule

//--- verilog/info_frames.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed InfoFrames for two-channel LPCM and RGB video
// Names are ASCII, first character in the top byte
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module info_frames
    import hdmi_packet_pkg::*;
    import audio_pkg::*;
#(
    parameter int           VIDEO_ID_CODE       = 1,
    parameter int           AUDIO_RATE          = 48000,
    parameter int           AUDIO_BIT_WIDTH     = 16,
    parameter logic [63:0]  VENDOR_NAME         = "Unknown ",
    parameter logic [127:0] PRODUCT_DESCRIPTION = "FPGA HDMI Source"
)
(
    input  logic [7:0] packet_type,
    output packet_t    packet
);

localparam logic [3:0] IEC_FS = sampling_frequency_code(AUDIO_RATE);
// CEA-861 frequency code from the IEC one
localparam logic [2:0] CEA_FS = IEC_FS == 4'b0011 ? 3'd1 : IEC_FS == 4'b0000 ? 3'd2
                              : IEC_FS == 4'b0010 ? 3'd3 : IEC_FS == 4'b1000 ? 3'd4
                              : IEC_FS == 4'b1010 ? 3'd5 : IEC_FS == 4'b1100 ? 3'd6
                              : IEC_FS == 4'b1110 ? 3'd7 : 3'd0;
localparam logic [1:0] CEA_SS = AUDIO_BIT_WIDTH == 16 ? 2'd1 : AUDIO_BIT_WIDTH == 20 ? 2'd2
                              : AUDIO_BIT_WIDTH == 24 ? 2'd3 : 2'd0;
// 4:3 for the two 640x480 and 480p codes, 16:9 otherwise
localparam logic [1:0] ASPECT = (VIDEO_ID_CODE == 1 || VIDEO_ID_CODE == 2) ? 2'b01 : 2'b10;

logic [27:0][7:0] audio_pb;
logic [27:0][7:0] avi_pb;
logic [27:0][7:0] spd_pb;

function automatic packet_t build_frame(input logic [7:0] kind, input logic [7:0] version,
                                        input logic [7:0] length, input packet_body_t payload);
    packet_t frame;
    frame.header = '{hb2: length, hb1: version, hb0: kind};
    frame.body = payload;
    frame.body[0][7:0] = info_frame_checksum(frame.header, payload);
    return frame;
endfunction

// Two channels, coding type taken from the stream
assign audio_pb = {176'd0, 8'h00, 8'h00, 8'h00, {3'b000, CEA_FS, CEA_SS}, 8'h01, 8'h00};
assign avi_pb = {176'd0, 8'h00, {1'b0, 7'(VIDEO_ID_CODE)}, 8'h00,
                 {2'b00, ASPECT, 4'b1000}, 8'h00, 8'h00};

always_comb
begin
    spd_pb = '0;
    for (int i = 0; i < 8; i++)
        spd_pb[1 + i] = VENDOR_NAME[8*(7 - i) +: 8];
    for (int i = 0; i < 16; i++)
        spd_pb[9 + i] = PRODUCT_DESCRIPTION[8*(15 - i) +: 8];
end

always_comb
begin
    case (packet_type)
        PKT_AUDIO_INFO: packet = build_frame(PKT_AUDIO_INFO, 8'd1, 8'd10, audio_pb);
        PKT_AVI:        packet = build_frame(PKT_AVI, 8'd2, 8'd13, avi_pb);
        PKT_SPD:        packet = build_frame(PKT_SPD, 8'd1, 8'd25, spd_pb);
        default:        packet = '0;
    endcase
end

endmodule

//--- verilog/audio_sample_packet.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Valid, user and channel-status bits are sent as zero
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module audio_sample_packet
    import hdmi_packet_pkg::*;
    import audio_pkg::*;
#(
    parameter int AUDIO_RATE      = 48000,
    parameter int AUDIO_BIT_WIDTH = 16
)
(
    input  logic              clk_pixel,
    input  logic              audio_buffer_rst,
    input  logic              latch,
    input  audio_pair_t [3:0] sample_buffer,
    input  logic [3:0]        samples_present,
    input  logic [7:0]        frame_counter,
    output packet_t           packet
);

localparam int MAX_SAMPLES = max_samples_per_packet(AUDIO_RATE);
localparam logic [3:0] PRESENT_MASK = 4'((1 << MAX_SAMPLES) - 1);
localparam logic [23:0] WORD_MASK = ~((24'd1 << (24 - AUDIO_BIT_WIDTH)) - 24'd1);

packet_t    fresh;
packet_t    held;
logic [3:0] present;
logic [3:0] block_start;

// Byte 6 holds parity at bits 7 and 3; parity covers the sample alone
function automatic logic [55:0] subpacket(input audio_pair_t pair);
    logic [23:0] left;
    logic [23:0] right;
    left = pair.left & WORD_MASK;
    right = pair.right & WORD_MASK;
    return {^right, 3'b000, ^left, 3'b000, right, left};
endfunction

always_comb
begin
    logic [8:0] frame_index;
    present = samples_present & PRESENT_MASK;
    for (int i = 0; i < 4; i++)
    begin
        frame_index = {1'b0, frame_counter} + 9'(i);
        block_start[i] = present[i] && (frame_index == 9'd0 || frame_index == 9'd192);
        fresh.body[i] = present[i] ? subpacket(sample_buffer[i]) : 56'd0;
    end
    fresh.header = '{hb2: {block_start, 4'b0000}, hb1: {4'b0000, present},
                     hb0: PKT_AUDIO_SAMPLE};
end

// Held copy lets the buffer refill while the slot is on the wire
always_ff @(posedge clk_pixel)
begin
    if (audio_buffer_rst)
        held.header <= '{hb2: 8'h00, hb1: 8'h00, hb0: PKT_AUDIO_SAMPLE};
    else if (latch)
        held.header <= fresh.header;
    if (latch)
        held.body <= fresh.body;
end

assign packet = latch ? fresh : held;

endmodule

//--- verilog/audio_clock_regen.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clk_audio is 128 fs; CTS is fixed by the rates, not measured
// Reset reaches the counter only if held over two clk_audio edges
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module audio_clock_regen
    import hdmi_packet_pkg::*;
#(
    parameter int VIDEO_RATE = 25_200_000,
    parameter int AUDIO_RATE = 48000,
    parameter int ACR_N      = 6144
)
(
    input  logic    clk_pixel,
    input  logic    clk_audio,
    input  logic    audio_buffer_rst,
    output logic    acr_wrap,
    output packet_t packet
);

localparam longint CTS_FULL = longint'(VIDEO_RATE) * longint'(ACR_N)
                              / (longint'(128) * longint'(AUDIO_RATE));
localparam logic [19:0] CTS = 20'(CTS_FULL);
localparam logic [19:0] N = 20'(ACR_N);
localparam int COUNT_WIDTH = $clog2(ACR_N + 1);
// SB0 low, then CTS and N with their top nibbles first
localparam logic [55:0] ACR_SUB = {N[7:0], N[15:8], 4'h0, N[19:16],
                                   CTS[7:0], CTS[15:8], 4'h0, CTS[19:16], 8'h00};

logic [COUNT_WIDTH-1:0] audio_count = '0;
logic                   wrap_toggle = 1'b0;
logic [1:0]             rst_audio_sync = 2'b00;
logic [1:0]             wrap_sync;

// N cycles of 128 fs span one CTS period
always_ff @(posedge clk_audio)
begin
    rst_audio_sync <= {rst_audio_sync[0], audio_buffer_rst};
    if (rst_audio_sync[1])
        audio_count <= '0;
    else if (audio_count == COUNT_WIDTH'(ACR_N - 1))
    begin
        audio_count <= '0;
        wrap_toggle <= ~wrap_toggle;
    end
    else
        audio_count <= audio_count + 1'b1;
end

always_ff @(posedge clk_pixel)
    wrap_sync <= {wrap_sync[0], wrap_toggle};

assign acr_wrap = wrap_sync[1];
assign packet.header = '{hb2: 8'h00, hb1: 8'h00, hb0: PKT_ACR};
assign packet.body = {4{ACR_SUB}};

endmodule

//--- verilog/audio_sample_collector.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// clk_audio must run slower than half of clk_pixel
// The clk_audio side starts from its power-up state
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module audio_sample_collector
    import audio_pkg::*;
#(
    parameter int AUDIO_BIT_WIDTH = 16,
    parameter int DEPTH           = 2
)
(
    input  logic              clk_pixel,
    input  logic              clk_audio,
    input  logic              audio_buffer_rst,
    input  logic              sample_strobe,
    input  audio_pair_t       audio_sample_word,
    input  logic              take_samples,
    output logic [2:0]        samples_waiting,
    output audio_pair_t [3:0] sample_buffer
);

localparam logic [23:0] WORD_MASK = ~((24'd1 << (24 - AUDIO_BIT_WIDTH)) - 24'd1);

audio_pair_t held_pair;
logic        transfer_toggle = 1'b0;
logic [1:0]  toggle_sync;
logic        toggle_seen;
logic        new_sample;

// Hold the pair steady until the pixel side has picked it up
always_ff @(posedge clk_audio)
begin
    if (sample_strobe)
    begin
        held_pair.left <= audio_sample_word.left & WORD_MASK;
        held_pair.right <= audio_sample_word.right & WORD_MASK;
        transfer_toggle <= ~transfer_toggle;
    end
end

always_ff @(posedge clk_pixel)
begin
    toggle_sync <= {toggle_sync[0], transfer_toggle};
    toggle_seen <= toggle_sync[1];
end

assign new_sample = toggle_sync[1] ^ toggle_seen;

always_ff @(posedge clk_pixel)
begin
    if (audio_buffer_rst)
        samples_waiting <= 3'd0;
    else if (take_samples)
        samples_waiting <= {2'b00, new_sample};
    else if (new_sample && samples_waiting < DEPTH)
        samples_waiting <= samples_waiting + 3'd1;
end

// A sample landing on the take cycle starts the next packet
always_ff @(posedge clk_pixel)
begin
    if (new_sample)
    begin
        if (take_samples)
            sample_buffer[0] <= held_pair;
        else if (samples_waiting < DEPTH)
            sample_buffer[samples_waiting[1:0]] <= held_pair;
    end
end

count_within_depth: assert property (@(posedge clk_pixel) disable iff (audio_buffer_rst)
    new_sample && !take_samples |-> samples_waiting < DEPTH);

endmodule

//--- verilog/audio_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sample words are 24 bits, left-justified, zero below the width
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package audio_pkg;

    typedef struct packed {
        logic [23:0] left;
        logic [23:0] right;
    } audio_pair_t;

    // Pairs one audio sample packet may carry at a given rate
    function automatic int max_samples_per_packet(input int audio_rate);
        if (audio_rate <= 48000)
            return 2;
        else if (audio_rate <= 88200)
            return 3;
        return 4;
    endfunction

    // IEC 60958-3 channel status bits 24 to 27
    function automatic logic [3:0] sampling_frequency_code(input int audio_rate);
        case (audio_rate)
            32000:   return 4'b0011;
            44100:   return 4'b0000;
            48000:   return 4'b0010;
            88200:   return 4'b1000;
            96000:   return 4'b1010;
            176400:  return 4'b1100;
            192000:  return 4'b1110;
            // Rate not indicated
            default: return 4'b0001;
        endcase
    endfunction

endpackage

//--- verilog/hdmi_packet_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Subpacket 0 sits in the low bits of the body, byte 0 lowest
// The checksum expects PB0 of the body to be zero when called
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package hdmi_packet_pkg;

    typedef struct packed {
        logic [7:0] hb2;
        logic [7:0] hb1;
        logic [7:0] hb0;
    } packet_header_t;

    typedef logic [3:0][55:0] packet_body_t;

    typedef struct packed {
        packet_header_t header;
        packet_body_t   body;
    } packet_t;

    localparam logic [7:0] PKT_NULL         = 8'h00;
    localparam logic [7:0] PKT_ACR          = 8'h01;
    localparam logic [7:0] PKT_AUDIO_SAMPLE = 8'h02;
    localparam logic [7:0] PKT_AVI          = 8'h82;
    localparam logic [7:0] PKT_SPD          = 8'h83;
    localparam logic [7:0] PKT_AUDIO_INFO   = 8'h84;

    // Byte that brings header plus all 28 body bytes to zero mod 256
    function automatic logic [7:0] info_frame_checksum(input packet_header_t header,
                                                       input packet_body_t body);
        logic [7:0] sum;
        logic [223:0] flat;
        flat = body;
        sum = header.hb0 + header.hb1 + header.hb2;
        for (int i = 0; i < 28; i++)
            sum = sum + flat[8*i +: 8];
        return 8'd0 - sum;
    endfunction

endpackage
